//--- list.f
+incdir+rtl
+incdir+verification
rtl/datapath_pkg.sv
rtl/datapath_ctrl_if.sv
rtl/register_file.sv
rtl/special_registers.sv
rtl/bus_selector.sv
rtl/alu.sv
rtl/datapath_top.sv
verification/datapath_tb.sv

//--- rtl/alu.sv
`timescale 1ns/1ps
`include "datapath_defines.svh"

module alu (
    datapath_ctrl_if.sink_alu   ctrl,
    input  datapath_pkg::word_t a,
    input  datapath_pkg::word_t b,
    output datapath_pkg::wide_t result
);
    import datapath_pkg::*;

    localparam int SHAMT_WIDTH = $clog2(`DP_WIDTH);

    logic [SHAMT_WIDTH-1:0]       shamt;
    logic [2*`DP_WIDTH-1:0]       ror_wide;
    logic [2*`DP_WIDTH-1:0]       rol_wide;
    logic signed [2*`DP_WIDTH-1:0] product;
    logic signed [`DP_WIDTH:0]    dividend_ext;
    logic signed [`DP_WIDTH:0]    divisor_ext;
    logic signed [`DP_WIDTH:0]    quotient_ext;
    logic signed [`DP_WIDTH:0]    remainder_ext;
    word_t                        quotient;
    word_t                        remainder;

    // shift and rotate amount from the low bits of b
    assign shamt = b[SHAMT_WIDTH-1:0];

    // rotates as shifts of the doubled word
    assign ror_wide = {a, a} >> shamt;
    assign rol_wide = {a, a} << shamt;

    // full signed product
    assign product = $signed(a) * $signed(b);

    // one extra bit so MIN / -1 cannot overflow
    assign dividend_ext  = {a[`DP_WIDTH-1], a};
    assign divisor_ext   = {b[`DP_WIDTH-1], b};

    always_comb begin
        quotient_ext  = '0;
        remainder_ext = '0;
        if (divisor_ext != '0) begin
            quotient_ext  = dividend_ext / divisor_ext;
            remainder_ext = dividend_ext % divisor_ext;
        end
    end

    // divide by zero gives all ones and keeps the dividend as remainder
    assign quotient  = (b == '0) ? '1 : quotient_ext[`DP_WIDTH-1:0];
    assign remainder = (b == '0) ? a : remainder_ext[`DP_WIDTH-1:0];

    always_comb begin
        result = '0;
        case (ctrl.op)
            ALU_ADD:  result.lo = a + b;
            ALU_SUB:  result.lo = a - b;
            ALU_AND:  result.lo = a & b;
            ALU_OR:   result.lo = a | b;
            ALU_SHR:  result.lo = a >> shamt;
            ALU_SHRA: result.lo = $signed(a) >>> shamt;
            ALU_SHL:  result.lo = a << shamt;
            ALU_ROR:  result.lo = ror_wide[`DP_WIDTH-1:0];
            ALU_ROL:  result.lo = rol_wide[2*`DP_WIDTH-1:`DP_WIDTH];
            ALU_MUL:  result = wide_t'(product);
            ALU_DIV: begin
                result.hi = remainder;
                result.lo = quotient;
            end
            // unary ops take the bus operand
            ALU_NEG:  result.lo = -b;
            ALU_NOT:  result.lo = ~b;
            default:  result = '0;
        endcase
    end

endmodule

//--- rtl/bus_selector.sv
`timescale 1ns/1ps

module bus_selector (
    datapath_ctrl_if.sink_bus   ctrl,
    input  datapath_pkg::word_t reg_data,
    input  datapath_pkg::word_t hi_data,
    input  datapath_pkg::word_t lo_data,
    input  datapath_pkg::word_t zhi_data,
    input  datapath_pkg::word_t zlo_data,
    input  datapath_pkg::word_t pc_data,
    input  datapath_pkg::word_t mdr_data,
    input  datapath_pkg::word_t inport_data,
    output datapath_pkg::word_t bus
);
    import datapath_pkg::*;

    bus_src_t src;

    // fixed priority, general register first
    always_comb begin
        if (ctrl.reg_out) begin
            src = SRC_REG;
        end else if (ctrl.hi_out) begin
            src = SRC_HI;
        end else if (ctrl.lo_out) begin
            src = SRC_LO;
        end else if (ctrl.zhi_out) begin
            src = SRC_ZHI;
        end else if (ctrl.zlo_out) begin
            src = SRC_ZLO;
        end else if (ctrl.pc_out) begin
            src = SRC_PC;
        end else if (ctrl.mdr_out) begin
            src = SRC_MDR;
        end else if (ctrl.inport_out) begin
            src = SRC_INPORT;
        end else begin
            src = SRC_NONE;
        end
    end

    // source mux, idle bus reads as zero
    always_comb begin
        case (src)
            SRC_REG:    bus = reg_data;
            SRC_HI:     bus = hi_data;
            SRC_LO:     bus = lo_data;
            SRC_ZHI:    bus = zhi_data;
            SRC_ZLO:    bus = zlo_data;
            SRC_PC:     bus = pc_data;
            SRC_MDR:    bus = mdr_data;
            SRC_INPORT: bus = inport_data;
            default:    bus = '0;
        endcase
    end

endmodule

//--- rtl/datapath_ctrl_if.sv
`timescale 1ns/1ps
`include "datapath_defines.svh"

interface datapath_ctrl_if;
    import datapath_pkg::*;

    // general register strobes
    logic                         reg_out;
    logic                         reg_in;
    logic [`DP_REG_SEL_WIDTH-1:0] reg_sel;

    // special register load strobes
    logic pc_in;
    logic pc_increment;
    logic ir_in;
    logic y_in;
    logic z_in;
    logic hi_in;
    logic lo_in;
    logic mar_in;
    logic mdr_in;
    logic mdr_read;

    // bus drive strobes
    logic pc_out;
    logic hi_out;
    logic lo_out;
    logic zhi_out;
    logic zlo_out;
    logic mdr_out;
    logic inport_out;

    alu_op_t op;

    modport sink_regs (
        input reg_in, reg_sel, pc_in, pc_increment, ir_in, y_in, z_in,
              hi_in, lo_in, mar_in, mdr_in, mdr_read
    );

    modport sink_bus (
        input reg_out, hi_out, lo_out, zhi_out, zlo_out, pc_out, mdr_out, inport_out
    );

    modport sink_alu (input op);

endinterface

//--- rtl/datapath_defines.svh
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// data word width
`define DP_WIDTH 32

// general register count and index width
`define DP_REG_COUNT 16
`define DP_REG_SEL_WIDTH 4

// alu opcode width
`define DP_OP_WIDTH 5

`endif

//--- rtl/datapath_pkg.sv
`include "datapath_defines.svh"

package datapath_pkg;

    typedef logic [`DP_WIDTH-1:0] word_t;

    // opcodes not listed here produce a zero result
    typedef enum logic [`DP_OP_WIDTH-1:0] {
        ALU_ADD  = 5'b00011,
        ALU_SUB  = 5'b00100,
        ALU_AND  = 5'b00101,
        ALU_OR   = 5'b00110,
        ALU_SHR  = 5'b00111,
        ALU_SHRA = 5'b01000,
        ALU_SHL  = 5'b01001,
        ALU_ROR  = 5'b01010,
        ALU_ROL  = 5'b01011,
        ALU_MUL  = 5'b01111,
        ALU_DIV  = 5'b10000,
        ALU_NEG  = 5'b10001,
        ALU_NOT  = 5'b10010
    } alu_op_t;

    // bus sources, highest priority first
    typedef enum logic [3:0] {
        SRC_REG,
        SRC_HI,
        SRC_LO,
        SRC_ZHI,
        SRC_ZLO,
        SRC_PC,
        SRC_MDR,
        SRC_INPORT,
        SRC_NONE
    } bus_src_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } wide_t;

endpackage

//--- rtl/datapath_top.sv
`timescale 1ns/1ps
`include "datapath_defines.svh"

module datapath_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`DP_REG_SEL_WIDTH-1:0] reg_sel,
    input  logic                         reg_out,
    input  logic                         reg_in,
    input  logic                         pc_out,
    input  logic                         pc_in,
    input  logic                         pc_increment,
    input  logic                         ir_in,
    input  logic                         y_in,
    input  logic                         z_in,
    input  logic                         hi_in,
    input  logic                         lo_in,
    input  logic                         hi_out,
    input  logic                         lo_out,
    input  logic                         zhi_out,
    input  logic                         zlo_out,
    input  logic                         mar_in,
    input  logic                         mdr_in,
    input  logic                         mdr_out,
    input  logic                         mdr_read,
    input  logic                         inport_out,
    input  logic [`DP_OP_WIDTH-1:0]      op,
    input  logic [`DP_WIDTH-1:0]         m_data_in,
    input  logic [`DP_WIDTH-1:0]         inport_data,
    output logic [`DP_WIDTH-1:0]         bus,
    output logic [`DP_WIDTH-1:0]         mar_data,
    output logic [`DP_WIDTH-1:0]         mdr_data,
    output logic [`DP_WIDTH-1:0]         ir_data
);
    import datapath_pkg::*;

    word_t reg_data;
    word_t y_data;
    word_t zhi_data;
    word_t zlo_data;
    word_t hi_data;
    word_t lo_data;
    word_t pc_data;
    wide_t alu_result;

    datapath_ctrl_if i_ctrl ();

    // step strobes into the control bundle
    assign i_ctrl.reg_sel      = reg_sel;
    assign i_ctrl.reg_out      = reg_out;
    assign i_ctrl.reg_in       = reg_in;
    assign i_ctrl.pc_out       = pc_out;
    assign i_ctrl.pc_in        = pc_in;
    assign i_ctrl.pc_increment = pc_increment;
    assign i_ctrl.ir_in        = ir_in;
    assign i_ctrl.y_in         = y_in;
    assign i_ctrl.z_in         = z_in;
    assign i_ctrl.hi_in        = hi_in;
    assign i_ctrl.lo_in        = lo_in;
    assign i_ctrl.hi_out       = hi_out;
    assign i_ctrl.lo_out       = lo_out;
    assign i_ctrl.zhi_out      = zhi_out;
    assign i_ctrl.zlo_out      = zlo_out;
    assign i_ctrl.mar_in       = mar_in;
    assign i_ctrl.mdr_in       = mdr_in;
    assign i_ctrl.mdr_out      = mdr_out;
    assign i_ctrl.mdr_read     = mdr_read;
    assign i_ctrl.inport_out   = inport_out;
    assign i_ctrl.op           = alu_op_t'(op);

    register_file i_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (i_ctrl.sink_regs),
        .bus      (bus),
        .reg_data (reg_data)
    );

    special_registers i_special_registers (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (i_ctrl.sink_regs),
        .bus        (bus),
        .alu_result (alu_result),
        .m_data_in  (m_data_in),
        .y_data     (y_data),
        .zhi_data   (zhi_data),
        .zlo_data   (zlo_data),
        .hi_data    (hi_data),
        .lo_data    (lo_data),
        .pc_data    (pc_data),
        .ir_data    (ir_data),
        .mar_data   (mar_data),
        .mdr_data   (mdr_data)
    );

    bus_selector i_bus_selector (
        .ctrl        (i_ctrl.sink_bus),
        .reg_data    (reg_data),
        .hi_data     (hi_data),
        .lo_data     (lo_data),
        .zhi_data    (zhi_data),
        .zlo_data    (zlo_data),
        .pc_data     (pc_data),
        .mdr_data    (mdr_data),
        .inport_data (inport_data),
        .bus         (bus)
    );

    // y holds the first operand, the bus carries the second
    alu i_alu (
        .ctrl   (i_ctrl.sink_alu),
        .a      (y_data),
        .b      (bus),
        .result (alu_result)
    );

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps
`include "datapath_defines.svh"

module register_file (
    input  logic                clk,
    input  logic                rst_n,
    datapath_ctrl_if.sink_regs  ctrl,
    input  datapath_pkg::word_t bus,
    output datapath_pkg::word_t reg_data
);
    import datapath_pkg::*;

    word_t regs [`DP_REG_COUNT];

    // write port, loads the selected register from the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DP_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_in) begin
            regs[ctrl.reg_sel] <= bus;
        end
    end

    // read port shares the same index, like an ir field would
    assign reg_data = regs[ctrl.reg_sel];

endmodule

//--- rtl/special_registers.sv
`timescale 1ns/1ps

module special_registers (
    input  logic                clk,
    input  logic                rst_n,
    datapath_ctrl_if.sink_regs  ctrl,
    input  datapath_pkg::word_t bus,
    input  datapath_pkg::wide_t alu_result,
    input  datapath_pkg::word_t m_data_in,
    output datapath_pkg::word_t y_data,
    output datapath_pkg::word_t zhi_data,
    output datapath_pkg::word_t zlo_data,
    output datapath_pkg::word_t hi_data,
    output datapath_pkg::word_t lo_data,
    output datapath_pkg::word_t pc_data,
    output datapath_pkg::word_t ir_data,
    output datapath_pkg::word_t mar_data,
    output datapath_pkg::word_t mdr_data
);
    import datapath_pkg::*;

    word_t mdr_next;

    // mdr input mux, memory read data or bus
    assign mdr_next = ctrl.mdr_read ? m_data_in : bus;

    // operand and result registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_data   <= '0;
            zhi_data <= '0;
            zlo_data <= '0;
            hi_data  <= '0;
            lo_data  <= '0;
        end else begin
            if (ctrl.y_in) begin
                y_data <= bus;
            end
            // whole 64-bit alu result into the z pair
            if (ctrl.z_in) begin
                zhi_data <= alu_result.hi;
                zlo_data <= alu_result.lo;
            end
            if (ctrl.hi_in) begin
                hi_data <= bus;
            end
            if (ctrl.lo_in) begin
                lo_data <= bus;
            end
        end
    end

    // program counter, a bus load wins over increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_data <= '0;
        end else if (ctrl.pc_in) begin
            pc_data <= bus;
        end else if (ctrl.pc_increment) begin
            pc_data <= pc_data + word_t'(1);
        end
    end

    // instruction and memory interface registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir_data  <= '0;
            mar_data <= '0;
            mdr_data <= '0;
        end else begin
            if (ctrl.ir_in) begin
                ir_data <= bus;
            end
            if (ctrl.mar_in) begin
                mar_data <= bus;
            end
            if (ctrl.mdr_in) begin
                mdr_data <= mdr_next;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module datapath_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vdatapath_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

//--- verification/datapath_model.svh
`ifndef DATAPATH_MODEL_SVH
`define DATAPATH_MODEL_SVH

// reference state of the datapath registers
logic [31:0] m_regs [16];
logic [31:0] m_pc;
logic [31:0] m_ir;
logic [31:0] m_y;
logic [31:0] m_zhi;
logic [31:0] m_zlo;
logic [31:0] m_hi;
logic [31:0] m_lo;
logic [31:0] m_mar;
logic [31:0] m_mdr;

function automatic void reset_model();
    for (int i = 0; i < 16; i++) begin
        m_regs[i] = '0;
    end
    m_pc  = '0;
    m_ir  = '0;
    m_y   = '0;
    m_zhi = '0;
    m_zlo = '0;
    m_hi  = '0;
    m_lo  = '0;
    m_mar = '0;
    m_mdr = '0;
endfunction

// 64-bit result as {z high, z low}
function automatic logic [63:0] alu_model(logic [4:0] op, logic [31:0] a, logic [31:0] b);
    int          s;
    longint      sa;
    longint      sb;
    longint      q;
    longint      rm;
    logic [63:0] r;
    s  = int'(b[4:0]);
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    r  = '0;
    case (op)
        ALU_ADD:  r[31:0] = a + b;
        ALU_SUB:  r[31:0] = a - b;
        ALU_AND:  r[31:0] = a & b;
        ALU_OR:   r[31:0] = a | b;
        ALU_SHR:  r[31:0] = a >> s;
        ALU_SHRA: r[31:0] = (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0);
        ALU_SHL:  r[31:0] = a << s;
        ALU_ROR:  r[31:0] = (a >> s) | (a << (32 - s));
        ALU_ROL:  r[31:0] = (a << s) | (a >> (32 - s));
        ALU_MUL:  r = sa * sb;
        ALU_DIV: begin
            if (b == 32'h0) begin
                r = {a, 32'hffff_ffff};
            end else begin
                q  = sa / sb;
                rm = sa % sb;
                r  = {rm[31:0], q[31:0]};
            end
        end
        ALU_NEG:  r[31:0] = 32'h0 - b;
        ALU_NOT:  r[31:0] = ~b;
        default:  r = '0;
    endcase
    return r;
endfunction

// mask bits in priority order: reg, hi, lo, zhi, zlo, pc, mdr, inport
function automatic logic [31:0] bus_model(logic [7:0] mask, logic [3:0] sel,
                                          logic [31:0] inport);
    logic [31:0] vals [8];
    vals = '{m_regs[sel], m_hi, m_lo, m_zhi, m_zlo, m_pc, m_mdr, inport};
    for (int i = 0; i < 8; i++) begin
        if (mask[i]) begin
            return vals[i];
        end
    end
    return 32'h0;
endfunction

`endif

//--- verification/datapath_tb.sv
`timescale 1ns/1ps

module datapath_tb;
    import datapath_pkg::*;

    `include "datapath_model.svh"

    localparam int LOAD_COUNT = 60;
    localparam int ALU_COUNT = 200;
    localparam int EDGE_COUNT = 2 * 13;
    localparam int MEM_COUNT = 20;
    localparam int PC_COUNT = 10;
    localparam int PRIO_COUNT = 60;

    // one cycle per step, six steps per alu run
    localparam int STEP_COUNT = 10 + 17 + LOAD_COUNT + 16 + (ALU_COUNT + EDGE_COUNT) * 6
        + MEM_COUNT * 2 + PC_COUNT * 4 + PRIO_COUNT + 4;
    localparam int CYCLE_LIMIT = STEP_COUNT * 8 + 100;

    logic        clk;
    logic        rst_n;
    logic [3:0]  reg_sel;
    logic        reg_out, reg_in, pc_out, pc_in, pc_increment, ir_in, y_in, z_in;
    logic        hi_in, lo_in, hi_out, lo_out, zhi_out, zlo_out;
    logic        mar_in, mdr_in, mdr_out, mdr_read, inport_out;
    logic [4:0]  op;
    logic [31:0] m_data_in, inport_data;
    logic [31:0] bus, mar_data, mdr_data, ir_data;
    int          errors;
    int          cycles;

    logic [4:0] op_codes [13] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SHR, ALU_SHRA,
        ALU_SHL, ALU_ROR, ALU_ROL, ALU_MUL, ALU_DIV, ALU_NEG, ALU_NOT};

    datapath_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped at the cycle limit of %0d, errors: %0d", CYCLE_LIMIT, errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // new step on the rising edge with all strobes low
    task automatic start_step();
        @(posedge clk);
        {reg_out, reg_in, pc_out, pc_in, pc_increment, ir_in, y_in, z_in} <= '0;
        {hi_in, lo_in, hi_out, lo_out, zhi_out, zlo_out} <= '0;
        {mar_in, mdr_in, mdr_out, mdr_read, inport_out} <= '0;
        op <= '0;
    endtask

    task automatic drive_outs(logic [7:0] mask);
        {inport_out, mdr_out, pc_out, zlo_out, zhi_out, lo_out, hi_out, reg_out} <= mask;
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // put a source on the bus and compare in mid cycle
    task automatic read_bus(logic [7:0] mask, logic [3:0] sel, logic [31:0] inport);
        start_step();
        drive_outs(mask);
        reg_sel     <= sel;
        inport_data <= inport;
        @(negedge clk);
        check_word("bus", bus, bus_model(mask, sel, inport));
    endtask

    task automatic load_reg(logic [3:0] r, logic [31:0] val);
        start_step();
        inport_out  <= 1'b1;
        inport_data <= val;
        reg_sel     <= r;
        reg_in      <= 1'b1;
        m_regs[r]   = val;
    endtask

    task automatic alu_step(logic [4:0] code, logic [31:0] a, logic [31:0] b);
        logic [63:0] exp;
        load_reg(4'd1, a);
        load_reg(4'd2, b);
        start_step();
        reg_out <= 1'b1;
        reg_sel <= 4'd1;
        y_in    <= 1'b1;
        m_y     = m_regs[1];
        start_step();
        reg_out <= 1'b1;
        reg_sel <= 4'd2;
        op      <= code;
        z_in    <= 1'b1;
        exp     = alu_model(code, m_y, m_regs[2]);
        m_zhi   = exp[63:32];
        m_zlo   = exp[31:0];
        read_bus(8'h10, 4'd0, 32'h0);
        read_bus(8'h08, 4'd0, 32'h0);
    endtask

    initial begin
        logic [31:0] a, b, val;
        logic [4:0]  code;
        logic [7:0]  mask;
        void'($urandom(56));
        errors = 0;
        cycles = 0;
        rst_n = 1'b0;
        reg_sel = '0;
        {reg_out, reg_in, pc_out, pc_in, pc_increment, ir_in, y_in, z_in} = '0;
        {hi_in, lo_in, hi_out, lo_out, zhi_out, zlo_out} = '0;
        {mar_in, mdr_in, mdr_out, mdr_read, inport_out} = '0;
        op = '0;
        m_data_in = '0;
        inport_data = '0;
        reset_model();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // reset state
        read_bus(8'h00, 4'd0, 32'h0);
        check_word("mar_data", mar_data, 32'h0);
        check_word("mdr_data", mdr_data, 32'h0);
        check_word("ir_data", ir_data, 32'h0);
        for (int r = 0; r < 16; r++) begin
            read_bus(8'h01, 4'(r), 32'h0);
        end

        // random loads into general registers with overwrites
        for (int i = 0; i < LOAD_COUNT; i++) begin
            load_reg(4'($urandom_range(15)), $urandom);
        end
        for (int r = 0; r < 16; r++) begin
            read_bus(8'h01, 4'(r), 32'h0);
        end

        // every opcode with a zero divisor and a shift amount of 31
        for (int k = 0; k < 13; k++) begin
            alu_step(op_codes[k], $urandom, 32'h0);
            alu_step(op_codes[k], $urandom, 32'd31);
        end

        // random alu operations
        for (int i = 0; i < ALU_COUNT; i++) begin
            code = ($urandom_range(15) == 0) ? 5'($urandom) : op_codes[$urandom_range(12)];
            a = $urandom;
            b = $urandom;
            case ($urandom_range(5))
                0: b = 32'h0;
                1: b = 32'd31;
                2: b = 32'hffff_ffff;
                default: ;
            endcase
            alu_step(code, a, b);
        end

        // memory path and ir
        for (int i = 0; i < MEM_COUNT; i++) begin
            val = $urandom;
            start_step();
            inport_out  <= 1'b1;
            inport_data <= val;
            mar_in      <= 1'b1;
            ir_in       <= i[1];
            mdr_in      <= 1'b1;
            mdr_read    <= i[0];
            m_data_in   <= ~val ^ 32'(i);
            m_mar = val;
            if (i[1]) begin
                m_ir = val;
            end
            m_mdr = i[0] ? (~val ^ 32'(i)) : val;
            read_bus(8'h40, 4'd0, 32'h0);
            check_word("mar_data", mar_data, m_mar);
            check_word("mdr_data", mdr_data, m_mdr);
            check_word("ir_data", ir_data, m_ir);
        end

        // program counter loads and increments
        for (int i = 0; i < PC_COUNT; i++) begin
            val = $urandom;
            start_step();
            inport_out  <= 1'b1;
            inport_data <= val;
            pc_in       <= 1'b1;
            pc_increment <= i[0];
            m_pc = val;
            repeat (2) begin
                start_step();
                pc_increment <= 1'b1;
                m_pc = m_pc + 32'd1;
            end
            read_bus(8'h20, 4'd0, 32'h0);
        end

        // bus priority with several drivers
        load_reg(4'd5, $urandom);
        start_step();
        inport_out  <= 1'b1;
        inport_data <= 32'h1234_5678;
        hi_in       <= 1'b1;
        m_hi = 32'h1234_5678;
        start_step();
        inport_out  <= 1'b1;
        inport_data <= 32'h9abc_def0;
        lo_in       <= 1'b1;
        m_lo = 32'h9abc_def0;
        for (int i = 0; i < PRIO_COUNT; i++) begin
            mask = 8'($urandom);
            read_bus(mask, 4'($urandom_range(15)), $urandom);
        end
        start_step();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
